// File: compile.f
hdl/tlb_pkg.sv
hdl/tlb_entry_array.sv
hdl/tlb_search_port.sv
hdl/tlb_top.sv
tb/tlb_checker.sv
tb/tlb_tb.sv

// File: hdl/tlb_entry_array.sv
`default_nettype none

module tlb_entry_array #(
    parameter int tlb_num = tlb_pkg::TLB_NUM_DEFAULT
) (
    input  logic                                aclk,
    input  logic                                reset,

    // write port
    input  logic                                we,
    input  tlb_pkg::tlb_write_t                 w_cmd,

    // read port, by index
    input  logic [tlb_pkg::IDX_W-1:0]           r_index,
    output tlb_pkg::tlb_entry_t                 r_entry,

    // whole table, to the search ports
    output tlb_pkg::tlb_entry_t [tlb_num-1:0]   entries
);

    localparam int IDX_W = tlb_pkg::IDX_W;

    tlb_pkg::tlb_entry_t [tlb_num-1:0] table_q;

    // one-hot write select, none set for an index past the table
    logic [tlb_num-1:0] w_sel;

    for (genvar i = 0; i < tlb_num; i++) begin : g_wdec
        localparam logic [IDX_W-1:0] ENTRY_IDX = IDX_W'(i);

        assign w_sel[i] = we && (w_cmd.index == ENTRY_IDX);
    end

    // table registers
    always_ff @(posedge aclk) begin
        if (reset) begin
            table_q <= '0;
        end else begin
            for (int i = 0; i < tlb_num; i++) begin
                if (w_sel[i]) begin
                    table_q[i] <= w_cmd.entry;
                end
            end
        end
    end

    assign entries = table_q;

    // indexed read mux
    // indexes at or above tlb_num fall through and read as zero
    always_comb begin
        r_entry = '0;
        for (int i = 0; i < tlb_num; i++) begin
            if (r_index == IDX_W'(i)) begin
                r_entry = table_q[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // field widths of a MIPS-style joint TLB entry
    localparam int VPN2_W = 19;
    localparam int ASID_W = 8;
    localparam int PFN_W  = 20;
    localparam int ATTR_W = 3;

    // index field width, also the upper bound on the table size
    localparam int IDX_W       = 4;
    localparam int TLB_NUM_MAX = 2 ** IDX_W;

    localparam int TLB_NUM_DEFAULT = 16;

    // one page of an entry (25 bits)
    typedef struct packed {
        logic [PFN_W-1:0]  pfn;
        logic [ATTR_W-1:0] c;
        logic              d;
        logic              v;
    } tlb_page_t;

    // one table entry, even page in page0 and odd page in page1 (78 bits)
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    // lookup request from one search port (28 bits)
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic              odd_page;
        logic [ASID_W-1:0] asid;
    } tlb_search_req_t;

    // lookup result, all zero on a miss (30 bits)
    typedef struct packed {
        logic             found;
        logic [IDX_W-1:0] index;
        tlb_page_t        page;
    } tlb_search_rsp_t;

    // write command, qualified by a separate we strobe (82 bits)
    typedef struct packed {
        logic [IDX_W-1:0] index;
        tlb_entry_t       entry;
    } tlb_write_t;

endpackage

`default_nettype wire

// File: hdl/tlb_search_port.sv
`default_nettype none

module tlb_search_port #(
    parameter int tlb_num = tlb_pkg::TLB_NUM_DEFAULT
) (
    input  tlb_pkg::tlb_entry_t [tlb_num-1:0]   entries,
    input  tlb_pkg::tlb_search_req_t            req,
    output tlb_pkg::tlb_search_rsp_t            rsp
);

    localparam int IDX_W = tlb_pkg::IDX_W;

    // per-entry compare results
    logic [tlb_num-1:0] vpn2_eq;
    logic [tlb_num-1:0] asid_ok;
    logic [tlb_num-1:0] match;

    // lowest matching entry, one-hot
    logic [tlb_num-1:0] win;

    logic                hit;
    logic [IDX_W-1:0]    hit_index;
    tlb_pkg::tlb_entry_t hit_entry;

    for (genvar i = 0; i < tlb_num; i++) begin : g_match
        assign vpn2_eq[i] = (entries[i].vpn2 == req.vpn2);

        // a global entry ignores the asid
        assign asid_ok[i] = entries[i].g || (entries[i].asid == req.asid);

        assign match[i] = vpn2_eq[i] && asid_ok[i];
    end

    // isolate the lowest set bit, so that the lower index wins
    assign win = match & (~match + 1'b1);

    assign hit = |match;

    // encode the winner into an index
    // win is one-hot or zero, so an or-reduction is enough
    always_comb begin
        hit_index = '0;
        for (int i = 0; i < tlb_num; i++) begin
            if (win[i]) begin
                hit_index = hit_index | IDX_W'(i);
            end
        end
    end

    // and-or mux of the winning entry, zero on a miss
    always_comb begin
        hit_entry = '0;
        for (int i = 0; i < tlb_num; i++) begin
            if (win[i]) begin
                hit_entry = hit_entry | entries[i];
            end
        end
    end

    // odd/even page select
    always_comb begin
        rsp.found = hit;
        rsp.index = hit_index;
        if (req.odd_page) begin
            rsp.page = hit_entry.page1;
        end else begin
            rsp.page = hit_entry.page0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/tlb_top.sv
`default_nettype none

module tlb_top #(
    parameter int tlb_num = tlb_pkg::TLB_NUM_DEFAULT
) (
    input  logic                        aclk,
    input  logic                        reset,

    // search port 0, instruction side
    input  tlb_pkg::tlb_search_req_t    s0_req,
    output tlb_pkg::tlb_search_rsp_t    s0_rsp,

    // search port 1, data side
    input  tlb_pkg::tlb_search_req_t    s1_req,
    output tlb_pkg::tlb_search_rsp_t    s1_rsp,

    // write port
    input  logic                        we,
    input  tlb_pkg::tlb_write_t         w_cmd,

    // read port
    input  logic [tlb_pkg::IDX_W-1:0]   r_index,
    output tlb_pkg::tlb_entry_t         r_entry
);

    // table size must fit the index field
    if (tlb_num < 1 || tlb_num > tlb_pkg::TLB_NUM_MAX) begin : g_bad_size
        $error("tlb_top: tlb_num %0d outside 1..%0d", tlb_num, tlb_pkg::TLB_NUM_MAX);
    end

    tlb_pkg::tlb_entry_t [tlb_num-1:0] entries;

    tlb_entry_array #(
        .tlb_num (tlb_num)
    ) entry_array (
        .aclk    (aclk),
        .reset   (reset),
        .we      (we),
        .w_cmd   (w_cmd),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    // both ports see the table as it stands before any write this cycle
    tlb_search_port #(
        .tlb_num (tlb_num)
    ) search0 (
        .entries (entries),
        .req     (s0_req),
        .rsp     (s0_rsp)
    );

    tlb_search_port #(
        .tlb_num (tlb_num)
    ) search1 (
        .entries (entries),
        .req     (s1_req),
        .rsp     (s1_rsp)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the TLB testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tlb_tb -f compile.f -o tlb_sim

status=0
./obj_dir/tlb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation passed"

// File: tb/tlb_checker.sv
`default_nettype none

module tlb_checker #(
    parameter int tlb_num = tlb_pkg::TLB_NUM_DEFAULT
) (
    input logic                              aclk,
    input logic                              reset,
    input tlb_pkg::tlb_entry_t [tlb_num-1:0] entries,
    input tlb_pkg::tlb_search_req_t          s0_req,
    input tlb_pkg::tlb_search_rsp_t          s0_rsp,
    input tlb_pkg::tlb_search_req_t          s1_req,
    input tlb_pkg::tlb_search_rsp_t          s1_rsp,
    input logic                              we,
    input tlb_pkg::tlb_write_t               w_cmd,
    input logic [tlb_pkg::IDX_W-1:0]         r_index,
    input tlb_pkg::tlb_entry_t               r_entry
);

    timeunit 1ns;
    timeprecision 100ps;

    // a hit lies inside the table and names an entry that matches the request
    function automatic logic hit_matches(tlb_pkg::tlb_entry_t [tlb_num-1:0] tbl,
                                         tlb_pkg::tlb_search_req_t req,
                                         tlb_pkg::tlb_search_rsp_t rsp);
        tlb_pkg::tlb_entry_t e;
        if (int'(rsp.index) >= tlb_num) begin
            return 1'b0;
        end
        e = tbl[rsp.index];
        return (e.vpn2 == req.vpn2) && (e.g || (e.asid == req.asid));
    endfunction

    a_s0_index: assert property (@(posedge aclk) disable iff (reset)
        s0_rsp.found |-> hit_matches(entries, s0_req, s0_rsp))
        else $error("s0 hit index %0d outside the table or not matching", s0_rsp.index);

    a_s1_index: assert property (@(posedge aclk) disable iff (reset)
        s1_rsp.found |-> hit_matches(entries, s1_req, s1_rsp))
        else $error("s1 hit index %0d outside the table or not matching", s1_rsp.index);

    // both ports search the same table
    a_same_req: assert property (@(posedge aclk) disable iff (reset)
        (s0_req == s1_req) |-> (s0_rsp == s1_rsp))
        else $error("equal requests gave different responses");

    // written entry shows up on the read port one cycle later
    a_write_read: assert property (@(posedge aclk) disable iff (reset)
        (we && (int'(w_cmd.index) < tlb_num)) |=>
            ((r_index != $past(w_cmd.index)) || (r_entry == $past(w_cmd.entry))))
        else $error("r_entry does not hold the entry written at index %0d", r_index);

endmodule

bind tlb_top tlb_checker #(
    .tlb_num (tlb_num)
) checks (
    .aclk    (aclk),
    .reset   (reset),
    .entries (entries),
    .s0_req  (s0_req),
    .s0_rsp  (s0_rsp),
    .s1_req  (s1_req),
    .s1_rsp  (s1_rsp),
    .we      (we),
    .w_cmd   (w_cmd),
    .r_index (r_index),
    .r_entry (r_entry)
);

`default_nettype wire

// File: tb/tlb_tb.sv
`default_nettype none

module tlb_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TLB_NUM       = tlb_pkg::TLB_NUM_DEFAULT;
    localparam int IDX_W         = tlb_pkg::IDX_W;
    localparam int RESET_TIMEOUT = 100;
    localparam int MAX_LINES     = 10000;

    logic                     aclk;
    logic                     reset;
    tlb_pkg::tlb_search_req_t s0_req;
    tlb_pkg::tlb_search_rsp_t s0_rsp;
    tlb_pkg::tlb_search_req_t s1_req;
    tlb_pkg::tlb_search_rsp_t s1_rsp;
    logic                     we;
    tlb_pkg::tlb_write_t      w_cmd;
    logic [IDX_W-1:0]         r_index;
    tlb_pkg::tlb_entry_t      r_entry;

    // reference copy of the table
    tlb_pkg::tlb_entry_t model_table [TLB_NUM];
    logic [31:0]         lcg_state;

    tlb_top #(
        .tlb_num (TLB_NUM)
    ) dut (
        .aclk    (aclk),
        .reset   (reset),
        .s0_req  (s0_req),
        .s0_rsp  (s0_rsp),
        .s1_req  (s1_req),
        .s1_rsp  (s1_rsp),
        .we      (we),
        .w_cmd   (w_cmd),
        .r_index (r_index),
        .r_entry (r_entry)
    );

    initial aclk = 1'b0;
    always #5 aclk = ~aclk;

    initial begin : reset_gen
        reset = 1'b1;
        repeat (10) @(posedge aclk);
        #1;
        reset = 1'b0;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_entry(string name, tlb_pkg::tlb_entry_t exp, tlb_pkg::tlb_entry_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run("r_entry mismatch");
        end
    endtask

    task automatic check_rsp(string name, tlb_pkg::tlb_search_rsp_t exp,
                             tlb_pkg::tlb_search_rsp_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run("search response mismatch");
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic tlb_pkg::tlb_page_t make_page(logic [31:0] pfn, logic [31:0] c,
                                                     logic [31:0] d, logic [31:0] v);
        tlb_pkg::tlb_page_t p;
        p.pfn = pfn[tlb_pkg::PFN_W-1:0];
        p.c   = c[tlb_pkg::ATTR_W-1:0];
        p.d   = d[0];
        p.v   = v[0];
        return p;
    endfunction

    function automatic tlb_pkg::tlb_search_req_t make_req(logic [31:0] vpn2, logic [31:0] odd,
                                                          logic [31:0] asid);
        tlb_pkg::tlb_search_req_t q;
        q.vpn2     = vpn2[tlb_pkg::VPN2_W-1:0];
        q.odd_page = odd[0];
        q.asid     = asid[tlb_pkg::ASID_W-1:0];
        return q;
    endfunction

    // response for a known hit index, page taken from the model table
    function automatic tlb_pkg::tlb_search_rsp_t expect_at(logic found, logic [IDX_W-1:0] idx,
                                                           logic odd);
        tlb_pkg::tlb_search_rsp_t rsp;
        rsp = '0;
        if (found) begin
            rsp.found = 1'b1;
            rsp.index = idx;
            rsp.page  = odd ? model_table[idx].page1 : model_table[idx].page0;
        end
        return rsp;
    endfunction

    function automatic tlb_pkg::tlb_search_rsp_t model_search(tlb_pkg::tlb_search_req_t req);
        tlb_pkg::tlb_search_rsp_t rsp;
        rsp = '0;
        // walk downward, the last match kept is the lowest index
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (model_table[i].vpn2 == req.vpn2 &&
                (model_table[i].g || model_table[i].asid == req.asid)) begin
                rsp = expect_at(1'b1, IDX_W'(i), req.odd_page);
            end
        end
        return rsp;
    endfunction

    // small vpn2 and asid ranges so that random entries collide
    function automatic tlb_pkg::tlb_entry_t random_entry();
        logic [31:0]         r;
        tlb_pkg::tlb_entry_t e;
        r = next_random();
        e = '0;
        e.vpn2[5:0] = r[31:26];
        e.asid[1:0] = r[25:24];
        e.g         = r[23] & r[22];
        r = next_random();
        e.page0 = r[31:7];
        r = next_random();
        e.page1 = r[31:7];
        return e;
    endfunction

    function automatic tlb_pkg::tlb_search_req_t random_req();
        logic [31:0]              r;
        tlb_pkg::tlb_search_req_t q;
        r = next_random();
        q = '0;
        q.vpn2[5:0] = r[31:26];
        q.asid[1:0] = r[25:24];
        q.odd_page  = r[23];
        // half of the lookups reuse a stored vpn2
        if (r[22]) q.vpn2 = model_table[int'(r[21:18]) % TLB_NUM].vpn2;
        return q;
    endfunction

    task automatic drive_write(tlb_pkg::tlb_write_t cmd);
        we    = 1'b1;
        w_cmd = cmd;
        @(posedge aclk);
        #1;
        we = 1'b0;
        if (int'(cmd.index) < TLB_NUM) model_table[cmd.index] = cmd.entry;
    endtask

    task automatic check_read(string name, logic [IDX_W-1:0] idx);
        tlb_pkg::tlb_entry_t exp;
        exp = '0;
        if (int'(idx) < TLB_NUM) exp = model_table[idx];
        r_index = idx;
        #8;
        check_entry(name, exp, r_entry);
        @(posedge aclk);
        #1;
    endtask

    task automatic check_search(string name,
                                tlb_pkg::tlb_search_req_t q0, tlb_pkg::tlb_search_rsp_t e0,
                                tlb_pkg::tlb_search_req_t q1, tlb_pkg::tlb_search_rsp_t e1);
        s0_req = q0;
        s1_req = q1;
        #8;
        check_rsp({name, "/s0"}, e0, s0_rsp);
        check_rsp({name, "/s1"}, e1, s1_rsp);
        @(posedge aclk);
        #1;
    endtask

    task automatic run_write(string line);
        string               op;
        string               name;
        logic [31:0]         f [0:11];
        tlb_pkg::tlb_write_t cmd;
        int                  n;
        n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h", op, name,
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
        if (n != 14) abort_run({"malformed write line: ", line});
        cmd.index       = f[0][IDX_W-1:0];
        cmd.entry.vpn2  = f[1][tlb_pkg::VPN2_W-1:0];
        cmd.entry.asid  = f[2][tlb_pkg::ASID_W-1:0];
        cmd.entry.g     = f[3][0];
        cmd.entry.page0 = make_page(f[4], f[5], f[6], f[7]);
        cmd.entry.page1 = make_page(f[8], f[9], f[10], f[11]);
        drive_write(cmd);
    endtask

    task automatic run_read(string line);
        string       op;
        string       name;
        logic [31:0] idx;
        int          n;
        n = $sscanf(line, "%s %s %h", op, name, idx);
        if (n != 3) abort_run({"malformed read line: ", line});
        check_read(name, idx[IDX_W-1:0]);
    endtask

    task automatic run_search(string line);
        string                    op;
        string                    name;
        logic [31:0]              f [0:9];
        tlb_pkg::tlb_search_req_t q0;
        tlb_pkg::tlb_search_req_t q1;
        int                       n;
        n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h", op, name,
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
        if (n != 12) abort_run({"malformed search line: ", line});
        q0 = make_req(f[0], f[1], f[2]);
        q1 = make_req(f[5], f[6], f[7]);
        check_search(name, q0, expect_at(f[3][0], f[4][IDX_W-1:0], q0.odd_page),
                     q1, expect_at(f[8][0], f[9][IDX_W-1:0], q1.odd_page));
    endtask

    task automatic run_fill(string line);
        string                    op;
        string                    name;
        int                       count;
        int                       searches;
        int                       n;
        tlb_pkg::tlb_write_t      cmd;
        tlb_pkg::tlb_search_req_t q0;
        tlb_pkg::tlb_search_req_t q1;
        n = $sscanf(line, "%s %s %h %h", op, name, count, searches);
        if (n != 4) abort_run({"malformed fill line: ", line});
        for (int i = 0; i < count; i++) begin
            cmd.index = IDX_W'(i % TLB_NUM);
            cmd.entry = random_entry();
            drive_write(cmd);
        end
        for (int i = 0; i < searches; i++) begin
            q0 = random_req();
            q1 = random_req();
            check_search($sformatf("%s_%0d", name, i), q0, model_search(q0),
                         q1, model_search(q1));
        end
        for (int i = 0; i < TLB_NUM; i++) begin
            check_read($sformatf("%s_rd%0d", name, i), IDX_W'(i));
        end
    endtask

    initial begin : main
        int    fd;
        int    n;
        int    lines;
        int    cycles;
        string line;
        string op;
        string name;

        s0_req    = '0;
        s1_req    = '0;
        we        = 1'b0;
        w_cmd     = '0;
        r_index   = '0;
        lcg_state = 32'h3376_5035;
        for (int i = 0; i < TLB_NUM; i++) begin
            model_table[i] = '0;
        end

        fd = $fopen("tb/tlb_testdata.txt", "r");
        if (fd == 0) abort_run("could not open tb/tlb_testdata.txt");

        cycles = 0;
        do begin
            @(posedge aclk);
            cycles++;
            if (cycles > RESET_TIMEOUT) abort_run("reset was never released");
        end while (reset !== 1'b0);
        #1;

        lines = 0;
        while (!$feof(fd) && lines < MAX_LINES) begin
            lines++;
            line = "";
            n = $fgets(line, fd);
            if (n <= 0) continue;
            n = $sscanf(line, "%s %s", op, name);
            if (n < 2 || op == "#") continue;
            case (op)
                "write":  run_write(line);
                "read":   run_read(line);
                "search": run_search(line);
                "fill":   run_fill(line);
                default:  abort_run({"unknown operation in data file: ", op});
            endcase
        end
        $fclose(fd);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tlb_testdata.txt
# all numbers hex, op then test name then fields
# write  name idx vpn2 asid g pfn0 c0 d0 v0 pfn1 c1 d1 v1
# read   name idx  (expected entry is the table as written so far)
# search name s0: vpn2 odd asid found index  s1: vpn2 odd asid found index
# fill   name entries searches  (random entries from the LCG)
# after reset every entry reads as zero
read   rst_rd0 0
read   rst_rd1 1
read   rst_rd2 2
read   rst_rd3 3
read   rst_rd4 4
read   rst_rd5 5
read   rst_rd6 6
read   rst_rd7 7
read   rst_rd8 8
read   rst_rd9 9
read   rst_rda a
read   rst_rdb b
read   rst_rdc c
read   rst_rdd d
read   rst_rde e
read   rst_rdf f
search rst_hit   00000 0 00 1 0   00000 1 00 1 0
search rst_miss  00001 0 00 0 0   7ffff 1 ff 0 0
search rst_asid  00000 0 05 0 0   00000 1 00 1 0
# write then read
write  wr_a    3 12345 11 0 abcde 2 1 1 54321 3 0 1
read   wr_rd3  3
read   wr_rd2  2
read   wr_rd4  4
write  wr_b    9 7ffff ff 1 fffff 7 1 1 00001 0 0 0
read   wr_rd9  9
read   wr_rd3b 3
write  wr_c    f 00abc 22 0 11111 1 1 0 22222 4 0 1
read   wr_rdf  f
read   wr_rd0  0
read   wr_rd9b 9
# asid rule on index 3, global rule on index 9, page select
search asid_hit  12345 0 11 1 3   12345 1 11 1 3
search asid_miss 12345 0 12 0 0   12345 1 00 0 0
search glob_hit  7ffff 0 00 1 9   7ffff 1 5a 1 9
search glob_odd  7ffff 1 ff 1 9   00abc 1 22 1 f
search odd_sel   00abc 0 22 1 f   00abc 1 21 0 0
# same vpn2 and asid at two indexes, lower one wins
write  prio_hi     c 0abcd 33 0 0aaaa 1 0 1 0bbbb 2 1 1
write  prio_lo     5 0abcd 33 0 05555 3 1 1 06666 5 0 1
search prio_both   0abcd 0 33 1 5   0abcd 1 33 1 5
write  prio_move   5 01111 33 0 05555 3 1 1 06666 5 0 1
search prio_after  0abcd 0 33 1 c   0abcd 1 33 1 c
search prio_moved  01111 1 33 1 5   01111 0 34 0 0
read   prio_rd5    5
read   prio_rdc    c
write  prio_glob   1 0abcd 00 1 01234 0 0 1 04321 7 1 1
search prio_glob_s 0abcd 0 33 1 1   0abcd 1 44 1 1
search prio_glob_m 0abcd 1 44 1 1   0abce 1 33 0 0
# both ports in one cycle, each on its own
search dual_mix  12345 1 11 1 3   12346 0 11 0 0
search dual_two  00abc 0 22 1 f   7ffff 0 01 1 9
search dual_same 12345 0 11 1 3   12345 0 11 1 3
search dual_zero 00000 0 00 1 0   00000 0 01 0 0
search dual_miss 0abcd 0 34 1 1   54321 1 11 0 0
# random table against the reference model
fill   rand 10 40
